// File: logic/glb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// glb bank package
// widths, depths and request/response types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package glb_pkg;

    // bank geometry, byte addressed
    localparam int BANK_ADDR_WIDTH  = 12;
    localparam int BANK_DATA_WIDTH  = 64;
    localparam int CFG_DATA_WIDTH   = 32;
    // addr bit 2 picks the upper cfg half-word
    localparam int BANK_BYTE_OFFSET = 3;
    localparam int SRAM_DEPTH       = 512;
    localparam int SRAM_ADDR_WIDTH  = $clog2(SRAM_DEPTH);

    // request queue depth doubles as initial request credits
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int REQ_PTR_WIDTH  = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_CNT_WIDTH  = $clog2(REQ_FIFO_DEPTH + 1);

    // response slots owned by the consumer
    localparam int RSP_CREDITS   = 4;
    localparam int RSP_CNT_WIDTH = $clog2(RSP_CREDITS + 1);

    typedef logic [REQ_PTR_WIDTH-1:0]   req_ptr_t;
    typedef logic [REQ_CNT_WIDTH-1:0]   req_cnt_t;
    typedef logic [RSP_CNT_WIDTH-1:0]   rsp_cnt_t;
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;

    // packet side, full word with bit mask
    typedef struct packed {
        logic                       wr;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [BANK_DATA_WIDTH-1:0] bit_sel;
    } packet_req_t;

    typedef struct packed {
        logic                       valid;
        logic [BANK_DATA_WIDTH-1:0] data;
    } packet_rsp_t;

    // config side, half-word accesses
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [BANK_ADDR_WIDTH-1:0] wr_addr;
        logic [BANK_ADDR_WIDTH-1:0] rd_addr;
        logic [CFG_DATA_WIDTH-1:0]  wr_data;
    } cfg_req_t;

    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rsp_t;

    // one access toward the memory macro
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [BANK_DATA_WIDTH-1:0] data_in;
        logic [BANK_DATA_WIDTH-1:0] bit_sel;
    } sram_req_t;

endpackage

// File: logic/glb_req_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet request queue
// small circular buffer of pending requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_req_fifo (
    input  logic                clk,
    input  logic                reset,

    input  logic                push,
    input  glb_pkg::packet_req_t push_data,

    input  logic                pop,
    output glb_pkg::packet_req_t pop_data,
    output logic                empty
);

// storage, no reset on payload
glb_pkg::packet_req_t entries [glb_pkg::REQ_FIFO_DEPTH];

glb_pkg::req_ptr_t wr_ptr;
glb_pkg::req_ptr_t rd_ptr;
glb_pkg::req_cnt_t count;

// head is always visible
assign pop_data = entries[rd_ptr];
assign empty    = (count == '0);

// write side
always_ff @(posedge clk) begin
    if (push) begin
        entries[wr_ptr] <= push_data;
    end
end

// pointers wrap on their own, depth is a power of two
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
    end
    else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

// occupancy
// requester credits keep this from overflowing
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        count <= '0;
    end
    else begin
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

endmodule

// File: logic/glb_packet_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet port
// credit front end, queues and issues requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_packet_port (
    input  logic                 clk,
    input  logic                 reset,

    // requester side
    input  logic                 packet_req_valid,
    input  glb_pkg::packet_req_t packet_req,
    output logic                 req_credit,

    // consumer frees a response slot
    input  logic                 rsp_credit,

    // toward bank controller
    output logic                 pkt_valid,
    output glb_pkg::packet_req_t pkt,
    input  logic                 pkt_ready
);

glb_pkg::packet_req_t head;
logic                 q_empty;
logic                 q_pop;
logic                 xfer;
logic                 rd_take;
logic                 rsp_avail;
glb_pkg::rsp_cnt_t    rsp_cnt;

// pending request queue
glb_req_fifo req_q (
    .clk       (clk),
    .reset     (reset),
    .push      (packet_req_valid),
    .push_data (packet_req),
    .pop       (q_pop),
    .pop_data  (head),
    .empty     (q_empty)
);

assign rsp_avail = (rsp_cnt != '0);

// head waits if it is a read with no response slot
// writes behind it wait too, order is kept
assign pkt_valid = !q_empty && (head.wr || rsp_avail);
assign pkt       = head;

assign xfer    = pkt_valid && pkt_ready;
assign q_pop   = xfer;
// a read reserves its response slot on transfer
assign rd_take = xfer && !head.wr;

// one credit back per popped entry, a cycle later
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        req_credit <= 1'b0;
    end
    else begin
        req_credit <= q_pop;
    end
end

// response slot counter
// starts full, take on read issue, give on rsp_credit
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        rsp_cnt <= glb_pkg::rsp_cnt_t'(glb_pkg::RSP_CREDITS);
    end
    else begin
        case ({rsp_credit, rd_take})
            2'b10:   rsp_cnt <= rsp_cnt + 1'b1;
            2'b01:   rsp_cnt <= rsp_cnt - 1'b1;
            default: rsp_cnt <= rsp_cnt;
        endcase
    end
end

endmodule

// File: logic/glb_bank_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank controller
// arbitrates config and packet access to the sram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_bank_ctrl (
    input  logic                                clk,
    input  logic                                reset,

    // config agent, never refused
    input  glb_pkg::cfg_req_t                   cfg,
    output glb_pkg::cfg_rsp_t                   cfg_rsp,

    // packet agent
    input  logic                                pkt_valid,
    input  glb_pkg::packet_req_t                pkt,
    output logic                                pkt_ready,

    // memory side
    output glb_pkg::sram_req_t                  sram_req,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out,

    output glb_pkg::packet_rsp_t                packet_rsp
);

localparam int HW = glb_pkg::CFG_DATA_WIDTH;
localparam int UW = glb_pkg::BANK_DATA_WIDTH - glb_pkg::CFG_DATA_WIDTH;

// what kind of read is in flight
typedef struct packed {
    logic cfg_rd;
    logic pkt_rd;
    logic upper;
} rd_tag_t;

glb_pkg::sram_req_t sel;
rd_tag_t            sel_tag;
rd_tag_t            tag_d1;
rd_tag_t            tag_d2;
logic               run;
logic               cfg_busy;
logic               pkt_go;
logic               cfg_wr_upper;

// registered access, enables and payload split
logic                                wr_en_q;
logic                                rd_en_q;
logic [glb_pkg::BANK_ADDR_WIDTH-1:0] addr_q;
logic [glb_pkg::BANK_DATA_WIDTH-1:0] data_q;
logic [glb_pkg::BANK_DATA_WIDTH-1:0] bit_sel_q;

// last returned data, held between pulses
logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_hold;
logic [glb_pkg::BANK_DATA_WIDTH-1:0] pkt_hold;
logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_half;

// ready stays low until out of reset
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        run <= 1'b0;
    end
    else begin
        run <= 1'b1;
    end
end

assign cfg_busy     = cfg.wr_en || cfg.rd_en;
assign pkt_ready    = run && !cfg_busy;
assign pkt_go       = pkt_valid && pkt_ready;
assign cfg_wr_upper = cfg.wr_addr[glb_pkg::BANK_BYTE_OFFSET-1];

// priority: cfg write, cfg read, packet
always_comb begin
    sel     = '0;
    sel_tag = '0;
    if (cfg.wr_en) begin
        sel.wr_en = 1'b1;
        sel.addr  = cfg.wr_addr;
        // pack half-word into the addressed half
        if (cfg_wr_upper) begin
            sel.data_in = {cfg.wr_data, {UW{1'b0}}};
            sel.bit_sel = {{HW{1'b1}}, {UW{1'b0}}};
        end
        else begin
            sel.data_in = {{UW{1'b0}}, cfg.wr_data};
            sel.bit_sel = {{UW{1'b0}}, {HW{1'b1}}};
        end
    end
    else if (cfg.rd_en) begin
        sel.rd_en      = 1'b1;
        sel.addr       = cfg.rd_addr;
        sel_tag.cfg_rd = 1'b1;
        sel_tag.upper  = cfg.rd_addr[glb_pkg::BANK_BYTE_OFFSET-1];
    end
    else if (pkt_go) begin
        sel.addr = pkt.addr;
        if (pkt.wr) begin
            sel.wr_en   = 1'b1;
            sel.data_in = pkt.data;
            sel.bit_sel = pkt.bit_sel;
        end
        else begin
            sel.rd_en      = 1'b1;
            sel_tag.pkt_rd = 1'b1;
        end
    end
end

// stage 1 control and read tags
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        wr_en_q <= 1'b0;
        rd_en_q <= 1'b0;
        tag_d1  <= '0;
        tag_d2  <= '0;
    end
    else begin
        wr_en_q <= sel.wr_en;
        rd_en_q <= sel.rd_en;
        tag_d1  <= sel_tag;
        // tag lines up with sram read data
        tag_d2  <= tag_d1;
    end
end

// stage 1 payload
always_ff @(posedge clk) begin
    addr_q    <= sel.addr;
    data_q    <= sel.data_in;
    bit_sel_q <= sel.bit_sel;
end

assign sram_req = '{
    wr_en:   wr_en_q,
    rd_en:   rd_en_q,
    addr:    addr_q,
    data_in: data_q,
    bit_sel: bit_sel_q
};

// half-word steering for cfg reads
assign cfg_half = tag_d2.upper ? mem_data_out[HW +: HW] : mem_data_out[0 +: HW];

// capture returned data for hold
always_ff @(posedge clk) begin
    if (tag_d2.cfg_rd) begin
        cfg_hold <= cfg_half;
    end
    if (tag_d2.pkt_rd) begin
        pkt_hold <= mem_data_out;
    end
end

assign cfg_rsp.rd_data_valid = tag_d2.cfg_rd;
assign cfg_rsp.rd_data       = tag_d2.cfg_rd ? cfg_half : cfg_hold;

assign packet_rsp.valid = tag_d2.pkt_rd;
assign packet_rsp.data  = tag_d2.pkt_rd ? mem_data_out : pkt_hold;

endmodule

// File: logic/glb_bank_sram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank sram
// bit-masked write, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_bank_sram (
    input  logic                                clk,

    input  glb_pkg::sram_req_t                  sram_req,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out
);

// behaves like a macro, contents undefined at power up
logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem [glb_pkg::SRAM_DEPTH];

glb_pkg::sram_addr_t word_idx;

// word index sits above the byte offset
assign word_idx = sram_req.addr[glb_pkg::BANK_BYTE_OFFSET +: glb_pkg::SRAM_ADDR_WIDTH];

// only masked bits change
always_ff @(posedge clk) begin
    if (sram_req.wr_en) begin
        mem[word_idx] <= (mem[word_idx] & ~sram_req.bit_sel)
                       | (sram_req.data_in & sram_req.bit_sel);
    end
end

// read data one clock after rd_en
// output holds between reads
always_ff @(posedge clk) begin
    if (sram_req.rd_en) begin
        mem_data_out <= mem[word_idx];
    end
end

endmodule

// File: logic/glb_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// glb bank top
// packet port, controller and sram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_bank (
    input  logic                 clk,
    input  logic                 reset,

    // config agent
    input  glb_pkg::cfg_req_t    cfg,
    output glb_pkg::cfg_rsp_t    cfg_rsp,

    // packet requests under credit flow control
    input  logic                 packet_req_valid,
    input  glb_pkg::packet_req_t packet_req,
    output logic                 req_credit,

    // packet responses under credit flow control
    input  logic                 rsp_credit,
    output glb_pkg::packet_rsp_t packet_rsp
);

// port to controller
logic                 pkt_valid;
glb_pkg::packet_req_t pkt;
logic                 pkt_ready;

// controller to memory
glb_pkg::sram_req_t                  sram_req;
logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out;

glb_packet_port port0 (
    .clk              (clk),
    .reset            (reset),
    .packet_req_valid (packet_req_valid),
    .packet_req       (packet_req),
    .req_credit       (req_credit),
    .rsp_credit       (rsp_credit),
    .pkt_valid        (pkt_valid),
    .pkt              (pkt),
    .pkt_ready        (pkt_ready)
);

glb_bank_ctrl ctrl0 (
    .clk          (clk),
    .reset        (reset),
    .cfg          (cfg),
    .cfg_rsp      (cfg_rsp),
    .pkt_valid    (pkt_valid),
    .pkt          (pkt),
    .pkt_ready    (pkt_ready),
    .sram_req     (sram_req),
    .mem_data_out (mem_data_out),
    .packet_rsp   (packet_rsp)
);

// memory macro, no reset
glb_bank_sram sram0 (
    .clk          (clk),
    .sram_req     (sram_req),
    .mem_data_out (mem_data_out)
);

endmodule

// File: sim/glb_bank_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// glb bank reference model
// memory mirror, expected responses, credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GLB_BANK_MODEL_SVH
`define GLB_BANK_MODEL_SVH

// sram mirror indexed by word
logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_model [int];

// expected read data in issue order
logic [glb_pkg::BANK_DATA_WIDTH-1:0] exp_pkt [$];
logic [glb_pkg::CFG_DATA_WIDTH-1:0]  exp_cfg [$];
// negedge count at which each cfg read must show
int cfg_due [$];

// last data returned for the hold check
logic [glb_pkg::BANK_DATA_WIDTH-1:0] pkt_last;
logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_last;
logic pkt_known = 1'b0;
logic cfg_known = 1'b0;

// requester credits start full after reset
int req_credits = glb_pkg::REQ_FIFO_DEPTH;

// consumer slots still held
int   rsp_held = 0;
// consumer stalls its credit return while set
logic withhold = 1'b0;

// only masked bits take the new data
function automatic void model_write(input int word,
                                    input logic [glb_pkg::BANK_DATA_WIDTH-1:0] data,
                                    input logic [glb_pkg::BANK_DATA_WIDTH-1:0] mask);
    if (!mem_model.exists(word)) begin
        mem_model[word] = '0;
    end
    mem_model[word] = (mem_model[word] & ~mask) | (data & mask);
endfunction

// half-word seen by a cfg read
// addr bit 2 picks upper
function automatic logic [glb_pkg::CFG_DATA_WIDTH-1:0] model_half(input int word,
                                                                  input logic upper);
    if (upper) begin
        return mem_model[word][glb_pkg::CFG_DATA_WIDTH +: glb_pkg::CFG_DATA_WIDTH];
    end
    return mem_model[word][0 +: glb_pkg::CFG_DATA_WIDTH];
endfunction

`endif

// File: sim/glb_bank_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// glb bank testbench
// random cfg and packet traffic vs a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_bank_tb;

localparam int CLK_PERIOD  = 40;
localparam int HW          = glb_pkg::CFG_DATA_WIDTH;
localparam int DW          = glb_pkg::BANK_DATA_WIDTH;
// packet traffic on words 0..15 and cfg traffic on 16..31
localparam int CFG_BASE    = 16;
// init 32, masked pairs 64, cfg phase 64, dense 200, mixed 320
localparam int TOTAL_REQS  = 680;
localparam int WATCHDOG_NS = (TOTAL_REQS * 20 + 200) * CLK_PERIOD;

logic                 clk;
logic                 reset;
glb_pkg::cfg_req_t    cfg;
glb_pkg::cfg_rsp_t    cfg_rsp;
logic                 packet_req_valid;
glb_pkg::packet_req_t packet_req;
logic                 req_credit;
logic                 rsp_credit;
glb_pkg::packet_rsp_t packet_rsp;

logic [15:0] lfsr  = 16'd31;
int          cycle = 0;

`include "glb_bank_model.svh"

glb_bank dut0 (
    .clk              (clk),
    .reset            (reset),
    .cfg              (cfg),
    .cfg_rsp          (cfg_rsp),
    .packet_req_valid (packet_req_valid),
    .packet_req       (packet_req),
    .req_credit       (req_credit),
    .rsp_credit       (rsp_credit),
    .packet_rsp       (packet_rsp)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// run length bound
initial begin
    #(WATCHDOG_NS);
    stop_on_error("timeout, traffic or credits did not drain in time");
end

// 16-bit fibonacci lfsr with taps 16 14 13 11
// one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        r    = {r[62:0], fb};
    end
    return r;
endfunction

function automatic logic coin();
    logic [63:0] r;
    r = rand_bits(1);
    return r[0];
endfunction

task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_packet_rsp(input glb_pkg::packet_rsp_t got,
                                input glb_pkg::packet_rsp_t exp);
    if (got !== exp) begin
        stop_on_error($sformatf("ERROR packet_rsp valid=%h data=%h expected valid=%h data=%h",
                                got.valid, got.data, exp.valid, exp.data));
    end
endtask

task automatic check_cfg_rsp(input glb_pkg::cfg_rsp_t got, input glb_pkg::cfg_rsp_t exp);
    if (got !== exp) begin
        stop_on_error($sformatf("ERROR cfg_rsp rd_data_valid=%h rd_data=%h expected %h %h",
                                got.rd_data_valid, got.rd_data,
                                exp.rd_data_valid, exp.rd_data));
    end
endtask

// one clock of output checks at the falling edge before driving
task automatic next_cycle();
    glb_pkg::packet_rsp_t exp_p;
    glb_pkg::cfg_rsp_t    exp_c;
    @(negedge clk);
    cycle++;
    // packet responses in issue order
    if (packet_rsp.valid && exp_pkt.size() == 0) begin
        stop_on_error("packet response with no read outstanding");
    end
    else if (packet_rsp.valid) begin
        exp_p.valid = 1'b1;
        exp_p.data  = exp_pkt.pop_front();
        pkt_last    = exp_p.data;
        pkt_known   = 1'b1;
        rsp_held++;
        check_packet_rsp(packet_rsp, exp_p);
        if (rsp_held > glb_pkg::RSP_CREDITS) begin
            stop_on_error("more packet responses held than response credits");
        end
    end
    else if (pkt_known) begin
        exp_p.valid = 1'b0;
        exp_p.data  = pkt_last;
        check_packet_rsp(packet_rsp, exp_p);
    end
    // cfg reads land exactly on their due cycle
    if (cfg_due.size() != 0 && cfg_due[0] == cycle) begin
        exp_c.rd_data       = exp_cfg.pop_front();
        exp_c.rd_data_valid = 1'b1;
        void'(cfg_due.pop_front());
        cfg_last            = exp_c.rd_data;
        cfg_known           = 1'b1;
        check_cfg_rsp(cfg_rsp, exp_c);
    end
    else if (cfg_known) begin
        exp_c.rd_data       = cfg_last;
        exp_c.rd_data_valid = 1'b0;
        check_cfg_rsp(cfg_rsp, exp_c);
    end
    else if (cfg_rsp.rd_data_valid) begin
        stop_on_error("configuration response with no read pending");
    end
    // request credits come back one per request
    if (req_credit && req_credits == glb_pkg::REQ_FIFO_DEPTH) begin
        stop_on_error("request credit returned with no request outstanding");
    end
    else if (req_credit) begin
        req_credits++;
    end
    // consumer frees a slot after a random wait
    rsp_credit = 1'b0;
    if (rsp_held > 0 && !withhold && rand_bits(2) == 0) begin
        rsp_credit = 1'b1;
        rsp_held--;
    end
    packet_req_valid = 1'b0;
    cfg.wr_en        = 1'b0;
    cfg.rd_en        = 1'b0;
endtask

task automatic send_packet(input logic wr, input int word,
                           input logic [DW-1:0] data, input logic [DW-1:0] mask);
    while (req_credits == 0) begin
        next_cycle();
    end
    packet_req_valid   = 1'b1;
    packet_req.wr      = wr;
    packet_req.addr    = word << glb_pkg::BANK_BYTE_OFFSET;
    packet_req.data    = data;
    packet_req.bit_sel = mask;
    req_credits--;
    if (wr) begin
        model_write(word, data, mask);
    end
    else begin
        exp_pkt.push_back(mem_model[word]);
    end
endtask

task automatic cfg_write(input int word, input logic upper, input logic [HW-1:0] data);
    cfg.wr_en   = 1'b1;
    cfg.wr_addr = word << glb_pkg::BANK_BYTE_OFFSET;
    cfg.wr_addr[glb_pkg::BANK_BYTE_OFFSET-1] = upper;
    cfg.wr_data = data;
    // half-word lands in the addressed half only
    model_write(word, {data, data},
                upper ? {{HW{1'b1}}, {HW{1'b0}}} : {{HW{1'b0}}, {HW{1'b1}}});
endtask

task automatic cfg_read(input int word, input logic upper);
    cfg.rd_en   = 1'b1;
    cfg.rd_addr = word << glb_pkg::BANK_BYTE_OFFSET;
    cfg.rd_addr[glb_pkg::BANK_BYTE_OFFSET-1] = upper;
    exp_cfg.push_back(model_half(word, upper));
    cfg_due.push_back(cycle + 2);
endtask

// wait for all responses and request credits
task automatic drain();
    while (exp_pkt.size() != 0 || cfg_due.size() != 0
           || req_credits != glb_pkg::REQ_FIFO_DEPTH) begin
        next_cycle();
    end
endtask

task automatic random_traffic(input int n, input int cfg_bits, input logic stall);
    int sent;
    int w;
    sent = 0;
    while (sent < n) begin
        next_cycle();
        // long stretches with no response credit
        if (stall && rand_bits(5) == 0) begin
            withhold = !withhold;
        end
        if (rand_bits(cfg_bits) != 0) begin
            w = CFG_BASE + int'(rand_bits(4));
            if (coin()) begin
                cfg_write(w, coin(), rand_bits(HW));
            end
            else begin
                cfg_read(w, coin());
            end
            sent++;
        end
        if (req_credits > 0 && coin()) begin
            send_packet(coin(), int'(rand_bits(4)), rand_bits(DW), rand_bits(DW));
            sent++;
        end
    end
    withhold = 1'b0;
endtask

initial begin
    int w;
    int i;
    reset            = 1'b1;
    cfg              = '0;
    packet_req_valid = 1'b0;
    packet_req       = '0;
    rsp_credit       = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    // full-mask writes give every used word a known value
    for (w = 0; w < 2 * CFG_BASE; w++) begin
        next_cycle();
        send_packet(1'b1, w, rand_bits(DW), '1);
    end
    // masked writes each read back
    for (i = 0; i < 32; i++) begin
        w = int'(rand_bits(4));
        next_cycle();
        send_packet(1'b1, w, rand_bits(DW), rand_bits(DW));
        next_cycle();
        send_packet(1'b0, w, '0, '0);
    end
    drain();
    // cfg halves then cfg and packet views of them
    for (w = CFG_BASE; w < 2 * CFG_BASE; w++) begin
        next_cycle();
        cfg_write(w, 1'b0, rand_bits(HW));
        next_cycle();
        cfg_write(w, 1'b1, rand_bits(HW));
    end
    for (w = CFG_BASE; w < 2 * CFG_BASE; w++) begin
        next_cycle();
        cfg_read(w, coin());
    end
    for (w = CFG_BASE; w < 2 * CFG_BASE; w++) begin
        next_cycle();
        send_packet(1'b0, w, '0, '0);
    end
    drain();
    // dense cfg stream with stalled consumer and then mixed traffic
    random_traffic(200, 3, 1'b1);
    random_traffic(320, 1, 1'b0);
    drain();
    $display("Verification passed");
    $finish;
end

endmodule

// File: files.f
+incdir+sim
logic/glb_pkg.sv
logic/glb_req_fifo.sv
logic/glb_packet_port.sv
logic/glb_bank_ctrl.sv
logic/glb_bank_sram.sv
logic/glb_bank.sv
sim/glb_bank_tb.sv

// File: Bender.yml
package:
  name: glb_bank

sources:
  # bank RTL
  - files:
      - logic/glb_pkg.sv
      - logic/glb_req_fifo.sv
      - logic/glb_packet_port.sv
      - logic/glb_bank_ctrl.sv
      - logic/glb_bank_sram.sv
      - logic/glb_bank.sv
  # testbench and its model header
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/glb_bank_tb.sv
